// ==== source/playseq_pkg.sv ====
/*
  Shared types and constant tables for the four-button memory game.
  Holds the three fixed sequences, the start length per level and memory,
  and the tone half-periods. Modules import it inside their bodies.
*/
package playseq_pkg;

    typedef logic [3:0] entry_t;   // one-hot entry or button pattern
    typedef logic [3:0] addr_t;    // position in a sequence, 0 to 15
    typedef logic [4:0] seq_len_t; // sequence length, 1 to 16

    localparam logic [1:0] MEM_CUSTOM = 2'd3; // recordable memory
    localparam seq_len_t   FULL_LEN   = 5'd16;

    // --------------------------------------------------
    // fixed sequences, memories 0 to 2
    // --------------------------------------------------
    localparam entry_t FIXED_SEQ [0:2][0:15] = '{
        '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
          4'b0100, 4'b0010, 4'b0001, 4'b1000,
          4'b0010, 4'b0100, 4'b0001, 4'b1000,
          4'b1000, 4'b0010, 4'b0100, 4'b0001},
        '{4'b0100, 4'b0001, 4'b1000, 4'b0010,
          4'b0010, 4'b1000, 4'b0100, 4'b0001,
          4'b1000, 4'b0001, 4'b0010, 4'b0100,
          4'b0001, 4'b0100, 4'b1000, 4'b0010},
        '{4'b1000, 4'b1000, 4'b0001, 4'b0100,
          4'b0010, 4'b0001, 4'b0001, 4'b1000,
          4'b0100, 4'b0010, 4'b1000, 4'b0100,
          4'b0010, 4'b0010, 4'b0001, 4'b0100}
    };

    // start length, index {row, memory}; levels 2 and 3 share row 2
    localparam seq_len_t START_LEN [0:11] = '{
        5'd5, 5'd9, 5'd8, 5'd5,
        5'd6, 5'd9, 5'd6, 5'd5,
        5'd5, 5'd9, 5'd4, 5'd5
    };

    // tone half-period in clock cycles, by lowest lit led
    localparam logic [3:0] TONE_HALF [0:3] = '{4'd8, 4'd6, 4'd4, 4'd2};

endpackage

// ==== source/playseq_ctrl_if.sv ====
/*
  Command and status bundle between the game controller and the datapath.
  The controller drives strobes and levels, the datapath answers with
  compare results and timer pulses.
*/
`timescale 1ns/1ps

interface playseq_ctrl_if;

    // controller to datapath
    logic new_game;      // sample settings, load start length
    logic grow;          // length plus one
    logic clear_addr;
    logic step_addr;
    logic show;          // leds from memory during preview
    logic restart_timer;
    logic restart_led;
    logic record_write;
    logic count_win;
    logic count_loss;

    // datapath to controller
    logic press;         // one cycle on a button rising edge
    logic match;
    logic at_last;
    logic at_full;
    logic addr_wrap;
    logic timed_out;
    logic led_tick;

    modport control (
        output new_game, grow, clear_addr, step_addr, show,
        output restart_timer, restart_led, record_write, count_win, count_loss,
        input  press, match, at_last, at_full, addr_wrap, timed_out, led_tick
    );

    modport datapath (
        input  new_game, grow, clear_addr, step_addr, show,
        input  restart_timer, restart_led, record_write, count_win, count_loss,
        output press, match, at_last, at_full, addr_wrap, timed_out, led_tick
    );

endinterface

// ==== source/playseq_sequence_store.sv ====
/*
  Sequence memories: three fixed tables and one recordable 16-entry RAM.
  All four are read at the same address with one cycle of latency,
  and memory_select picks the output after the read register.
*/
`timescale 1ns/1ps

module playseq_sequence_store (
    input  logic                clock,
    input  logic [1:0]          memory_select,
    input  playseq_pkg::addr_t  address,
    input  logic                write,
    input  playseq_pkg::entry_t write_data,
    output playseq_pkg::entry_t data
);
    import playseq_pkg::*;

    entry_t custom_mem [0:15];
    entry_t fixed_q [0:2];
    entry_t custom_q;

    // --------------------------------------------------
    // registered reads, custom write port
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        for (int m = 0; m < 3; m++) begin
            fixed_q[m] <= FIXED_SEQ[m][address];
        end
        custom_q <= custom_mem[address];
        if (write) begin
            custom_mem[address] <= write_data;
        end
    end

    always_comb begin
        case (memory_select)
            2'd0:    data = fixed_q[0];
            2'd1:    data = fixed_q[1];
            2'd2:    data = fixed_q[2];
            default: data = custom_q; // MEM_CUSTOM
        endcase
    end

endmodule

// ==== source/playseq_timers.sv ====
/*
  Press timeout and LED pacing counters.
  restart_timer arms a one-shot timeout of 4, 2, 1 or 1/2 units;
  restart_led realigns a free-running tick every LED_TICKS cycles.
*/
`timescale 1ns/1ps

module playseq_timers #(
    parameter int TIMEOUT_UNIT = 5000,
    parameter int LED_TICKS    = 500
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       restart_timer,
    input  logic       restart_led,
    input  logic [1:0] timeout_select,
    input  logic       ignore_timeout,
    output logic       timed_out,
    output logic       led_tick
);

    localparam int TW = $clog2(4 * TIMEOUT_UNIT + 1);
    localparam int LW = $clog2(LED_TICKS + 1);

    logic [TW-1:0] t_count;
    logic [TW-1:0] t_limit;
    logic          t_active;
    logic          t_hit;
    logic [LW-1:0] l_count;

    // --------------------------------------------------
    // press timeout
    // --------------------------------------------------
    always_comb begin
        case (timeout_select)
            2'd0:    t_limit = TW'(4 * TIMEOUT_UNIT);
            2'd1:    t_limit = TW'(2 * TIMEOUT_UNIT);
            2'd2:    t_limit = TW'(TIMEOUT_UNIT);
            default: t_limit = TW'(TIMEOUT_UNIT / 2);
        endcase
    end

    assign t_hit     = t_active && (t_count == t_limit - TW'(1));
    assign timed_out = t_hit && !ignore_timeout;

    always_ff @(posedge clock) begin
        if (reset) begin
            t_count  <= '0;
            t_active <= 1'b0;
        end else if (restart_timer) begin
            t_count  <= '0;
            t_active <= 1'b1;
        end else if (t_active) begin
            t_count <= t_count + TW'(1);
            if (t_hit) t_active <= 1'b0; // one shot per restart
        end
    end

    // led pacing, wraps continuously
    assign led_tick = (l_count == LW'(LED_TICKS - 1));

    always_ff @(posedge clock) begin
        if (reset || restart_led || led_tick) begin
            l_count <= '0;
        end else begin
            l_count <= l_count + LW'(1);
        end
    end

endmodule

// ==== source/playseq_datapath.sv ====
/*
  Game datapath: address and length counters, button edge capture,
  comparison against the selected memory, LED and tone outputs, and the
  win and loss counters. Driven by the controller through playseq_ctrl_if.
*/
`timescale 1ns/1ps

module playseq_datapath #(
    parameter int TIMEOUT_UNIT = 5000,
    parameter int LED_TICKS    = 500
) (
    input  logic                clock,
    input  logic                reset,
    input  playseq_pkg::entry_t buttons,
    input  logic [1:0]          level,
    input  logic [1:0]          memory_select,
    input  logic [1:0]          timeout_select,
    input  logic                ignore_timeout,
    playseq_ctrl_if.datapath    ctrl,
    output playseq_pkg::entry_t leds,
    output logic                buzzer,
    output logic [3:0]          wins,
    output logic [3:0]          losses
);
    import playseq_pkg::*;

    logic [1:0] mem_q;   // settings held for the game
    logic [1:0] tsel_q;
    addr_t      addr;
    seq_len_t   len;
    logic [1:0] len_row;
    entry_t     btn_sync;
    entry_t     btn_capture;
    logic       any_prev;
    entry_t     mem_data;
    logic [1:0] tone_idx;
    logic [3:0] tone_count;

    // --------------------------------------------------
    // settings, address and length
    // --------------------------------------------------
    assign len_row = (level == 2'd3) ? 2'd2 : level;

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_q  <= '0;
            tsel_q <= '0;
            addr   <= '0;
            len    <= 5'd1;
        end else begin
            if (ctrl.new_game) begin
                mem_q  <= memory_select;
                tsel_q <= timeout_select;
                len    <= START_LEN[{len_row, memory_select}];
            end else if (ctrl.grow) begin
                len <= len + 5'd1;
            end
            if (ctrl.clear_addr) addr <= '0;
            else if (ctrl.step_addr) addr <= addr + 4'd1;
        end
    end

    assign ctrl.at_last   = ({1'b0, addr} == len - 5'd1);
    assign ctrl.at_full   = (len == FULL_LEN);
    assign ctrl.addr_wrap = (addr == 4'd15);

    // button sampling and rising edge of any button
    always_ff @(posedge clock) begin
        if (reset) begin
            btn_sync <= '0;
            any_prev <= 1'b0;
        end else begin
            btn_sync <= buttons;
            any_prev <= |btn_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.press) btn_capture <= btn_sync; // pattern of this press
    end

    assign ctrl.press = (|btn_sync) && !any_prev;
    assign ctrl.match = (btn_capture == mem_data);

    playseq_sequence_store i_store (
        .clock         (clock),
        .memory_select (mem_q),
        .address       (addr),
        .write         (ctrl.record_write),
        .write_data    (btn_capture),
        .data          (mem_data)
    );

    playseq_timers #(
        .TIMEOUT_UNIT (TIMEOUT_UNIT),
        .LED_TICKS    (LED_TICKS)
    ) i_timers (
        .clock          (clock),
        .reset          (reset),
        .restart_timer  (ctrl.restart_timer),
        .restart_led    (ctrl.restart_led),
        .timeout_select (tsel_q),
        .ignore_timeout (ignore_timeout),
        .timed_out      (ctrl.timed_out),
        .led_tick       (ctrl.led_tick)
    );

    // --------------------------------------------------
    // leds, tone and score
    // --------------------------------------------------
    assign leds = ctrl.show ? mem_data : buttons;

    // lowest lit led sets the pitch
    assign tone_idx = leds[0] ? 2'd0 : leds[1] ? 2'd1 : leds[2] ? 2'd2 : 2'd3;

    always_ff @(posedge clock) begin
        if (reset || leds == '0) begin
            buzzer     <= 1'b0;
            tone_count <= '0;
        end else if (tone_count >= TONE_HALF[tone_idx] - 4'd1) begin
            buzzer     <= ~buzzer;
            tone_count <= '0;
        end else begin
            tone_count <= tone_count + 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wins   <= '0;
            losses <= '0;
        end else begin
            if (ctrl.count_win && wins != 4'hf) wins <= wins + 4'd1;       // saturates
            if (ctrl.count_loss && losses != 4'hf) losses <= losses + 4'd1;
        end
    end

endmodule

// ==== source/playseq_control.sv ====
/*
  Game controller FSM: idle, record, preview, play, won and lost.
  In idle it records presses into the custom memory or starts a game.
  A game previews the sequence, checks the player's presses, and
  grows the sequence until a loss or a full-length win.
*/
`timescale 1ns/1ps

module playseq_control (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  logic             record,
    input  logic [1:0]       memory_select,
    playseq_ctrl_if.control  ctrl,
    output logic             playing,
    output logic             won,
    output logic             lost
);
    import playseq_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_REC,       // waiting for a press to record
        S_REC_WR,
        S_REC_DONE,  // memory full, wait for record release
        S_START,
        S_PV_WAIT,   // one cycle for the memory read
        S_PV_ON,
        S_PV_OFF,
        S_PV_END,    // dark gap after the last entry
        S_PLAY,
        S_CHECK,
        S_WON,
        S_LOST
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clock) begin
        if (reset) state <= S_IDLE;
        else       state <= next_state;
    end

    // --------------------------------------------------
    // next state and command strobes
    // --------------------------------------------------
    always_comb begin
        next_state         = state;
        ctrl.new_game      = 1'b0;
        ctrl.grow          = 1'b0;
        ctrl.clear_addr    = 1'b0;
        ctrl.step_addr     = 1'b0;
        ctrl.show          = 1'b0;
        ctrl.restart_timer = 1'b0;
        ctrl.restart_led   = 1'b0;
        ctrl.record_write  = 1'b0;
        ctrl.count_win     = 1'b0;
        ctrl.count_loss    = 1'b0;

        case (state)
            S_IDLE: begin
                if (start) begin
                    next_state = S_START;
                end else if (record && memory_select == MEM_CUSTOM) begin
                    ctrl.clear_addr = 1'b1;
                    next_state      = S_REC;
                end
            end
            S_REC: begin
                if (!record)         next_state = S_IDLE;
                else if (ctrl.press) next_state = S_REC_WR;
            end
            S_REC_WR: begin
                ctrl.record_write = 1'b1; // captured pattern at addr
                if (ctrl.addr_wrap) begin
                    next_state = S_REC_DONE;
                end else begin
                    ctrl.step_addr = 1'b1;
                    next_state     = S_REC;
                end
            end
            S_REC_DONE: begin
                if (!record) next_state = S_IDLE;
            end
            S_START: begin
                ctrl.new_game   = 1'b1;
                ctrl.clear_addr = 1'b1;
                next_state      = S_PV_WAIT;
            end
            S_PV_WAIT: begin
                ctrl.restart_led = 1'b1;
                next_state       = S_PV_ON;
            end
            S_PV_ON: begin
                ctrl.show = 1'b1;
                if (ctrl.led_tick) begin
                    if (ctrl.at_last) begin
                        next_state = S_PV_END;
                    end else begin
                        ctrl.step_addr = 1'b1; // read settles during the gap
                        next_state     = S_PV_OFF;
                    end
                end
            end
            S_PV_OFF: begin
                if (ctrl.led_tick) next_state = S_PV_ON;
            end
            S_PV_END: begin
                if (ctrl.led_tick) begin
                    ctrl.clear_addr    = 1'b1;
                    ctrl.restart_timer = 1'b1;
                    next_state         = S_PLAY;
                end
            end
            S_PLAY: begin
                if (ctrl.timed_out) begin
                    ctrl.count_loss = 1'b1;
                    next_state      = S_LOST;
                end else if (ctrl.press) begin
                    ctrl.restart_timer = 1'b1;
                    next_state         = S_CHECK;
                end
            end
            S_CHECK: begin
                if (!ctrl.match) begin
                    ctrl.count_loss = 1'b1;
                    next_state      = S_LOST;
                end else if (ctrl.at_last && ctrl.at_full) begin
                    ctrl.count_win = 1'b1;
                    next_state     = S_WON;
                end else if (ctrl.at_last) begin
                    ctrl.grow       = 1'b1; // round done, one entry longer
                    ctrl.clear_addr = 1'b1;
                    next_state      = S_PV_WAIT;
                end else begin
                    ctrl.step_addr = 1'b1;
                    next_state     = S_PLAY;
                end
            end
            S_WON, S_LOST: begin
                if (start) next_state = S_START;
            end
            default: next_state = S_IDLE;
        endcase
    end

    assign playing = (state inside {S_START, S_PV_WAIT, S_PV_ON, S_PV_OFF,
                                    S_PV_END, S_PLAY, S_CHECK});
    assign won  = (state == S_WON);
    assign lost = (state == S_LOST);

endmodule

// ==== source/playseq_top.sv ====
/*
  Top level of the memory game. Plain ports toward the board, with the
  controller and datapath joined by playseq_ctrl_if inside.
  TIMEOUT_UNIT and LED_TICKS set the timer lengths in clock cycles.
*/
`timescale 1ns/1ps

module playseq_top #(
    parameter int TIMEOUT_UNIT = 5000,
    parameter int LED_TICKS    = 500
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  logic       record,
    input  logic [3:0] buttons,
    input  logic [1:0] level,
    input  logic [1:0] memory_select,
    input  logic [1:0] timeout_select,
    input  logic       ignore_timeout,
    output logic [3:0] leds,
    output logic       buzzer,
    output logic       playing,
    output logic       won,
    output logic       lost,
    output logic [3:0] wins,
    output logic [3:0] losses
);

    playseq_ctrl_if ctrl ();

    playseq_control i_control (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .record        (record),
        .memory_select (memory_select),
        .ctrl          (ctrl.control),
        .playing       (playing),
        .won           (won),
        .lost          (lost)
    );

    playseq_datapath #(
        .TIMEOUT_UNIT (TIMEOUT_UNIT),
        .LED_TICKS    (LED_TICKS)
    ) i_datapath (
        .clock          (clock),
        .reset          (reset),
        .buttons        (buttons),
        .level          (level),
        .memory_select  (memory_select),
        .timeout_select (timeout_select),
        .ignore_timeout (ignore_timeout),
        .ctrl           (ctrl.datapath),
        .leds           (leds),
        .buzzer         (buzzer),
        .wins           (wins),
        .losses         (losses)
    );

endmodule

// ==== test/playseq_asserts.sv ====
/*
  Rule checks on the game top level that need no model.
  Covers tone timing, the end-of-game levels, one-hot leds and the
  score steps. Bound into every playseq_top instance.
*/
`timescale 1ns/1ps

module playseq_asserts (
    input logic       clock,
    input logic       reset,
    input logic       start,
    input logic [3:0] leds,
    input logic       buzzer,
    input logic       playing,
    input logic       won,
    input logic       lost,
    input logic [3:0] wins,
    input logic [3:0] losses
);
    import playseq_pkg::*;

    int         fail_count = 0;
    logic [3:0] leds_q;
    logic       buzzer_q;
    logic [3:0] steady;   // samples with the same leds and no toggle
    logic [3:0] half;     // half-period of the lowest lit led

    always_comb begin
        half = TONE_HALF[3];
        for (int i = 3; i >= 0; i--) begin
            if (leds[i]) half = TONE_HALF[i];
        end
    end

    always_ff @(posedge clock) begin
        leds_q   <= leds;
        buzzer_q <= buzzer;
        if (reset || leds != leds_q || buzzer != buzzer_q) begin
            steady <= '0;
        end else if (steady != 4'hf) begin
            steady <= steady + 4'd1;
        end
    end

    // tone only while something is lit
    assert property (@(posedge clock) disable iff (reset) $rose(buzzer) |-> $past(leds) != 0)
        else begin
            fail_count++;
            $error("buzzer started with all leds dark");
        end
    assert property (@(posedge clock) disable iff (reset) $past(leds) == 0 |-> !buzzer)
        else begin
            fail_count++;
            $error("buzzer high after dark leds");
        end

    // while the same leds stay lit the buzzer flips every half-period
    assert property (@(posedge clock) disable iff (reset)
                     leds != 0 && leds == leds_q
                     |-> (buzzer != buzzer_q) == (steady == half - 4'd1))
        else begin
            fail_count++;
            $error("buzzer half-period does not match the lowest lit led");
        end

    // won and lost hold until the next start
    assert property (@(posedge clock) disable iff (reset)
                     $fell(won) || $fell(lost) |-> $past(start))
        else begin
            fail_count++;
            $error("game end level dropped without a start");
        end

    assert property (@(posedge clock) disable iff (reset) playing |-> $onehot0(leds))
        else begin
            fail_count++;
            $error("more than one led lit during a game");
        end

    // score moves by one at most
    assert property (@(posedge clock) disable iff (reset)
                     wins != $past(wins) |-> wins == $past(wins) + 4'd1)
        else begin
            fail_count++;
            $error("wins jumped");
        end
    assert property (@(posedge clock) disable iff (reset)
                     losses != $past(losses) |-> losses == $past(losses) + 4'd1)
        else begin
            fail_count++;
            $error("losses jumped");
        end

endmodule

bind playseq_top playseq_asserts i_asserts (.*);

// ==== test/playseq_tb.sv ====
/*
  Testbench for the memory game top level.
  Records a custom sequence, then plays fixed and custom games against a
  model built from the package tables. Presses, timeouts and the score
  counters are checked by assertions; a watchdog bounds the run.
*/
`timescale 1ns/1ps

module playseq_tb;
    import playseq_pkg::*;

    localparam int TIMEOUT_UNIT = 40;
    localparam int LED_TICKS    = 6;
    localparam int WAIT_LIT     = 4 * LED_TICKS + 20;
    localparam int WATCH_CYCLES = 8 * 16 * 16 * (2 * LED_TICKS + 8) + 32 * TIMEOUT_UNIT;

    logic       clock = 1'b0;
    logic       reset, start, record, ignore_timeout;
    logic [3:0] buttons;
    logic [1:0] level, memory_select, timeout_select;
    logic [3:0] leds, wins, losses;
    logic       buzzer, playing, won, lost;

    int     errors = 0;
    int     seed = 41590;
    int     exp_wins = 0;
    int     exp_losses = 0;
    entry_t exp_seq [0:15];
    entry_t custom_seq [0:15];

    playseq_top #(
        .TIMEOUT_UNIT (TIMEOUT_UNIT),
        .LED_TICKS    (LED_TICKS)
    ) i_playseq_top (.*);

    always #50 clock = ~clock;

    // score counters must already hold the new value when the level rises
    assert property (@(posedge clock) disable iff (reset) $rose(won) |-> wins == exp_wins)
        else begin
            errors++;
            $display("MISMATCH %0t: wins %0d, expected %0d", $time, wins, exp_wins);
        end
    assert property (@(posedge clock) disable iff (reset) $rose(lost) |-> losses == exp_losses)
        else begin
            errors++;
            $display("MISMATCH %0t: losses %0d, expected %0d", $time, losses, exp_losses);
        end

    // --------------------------------------------------
    // stimulus helpers, all entered on a falling edge
    // --------------------------------------------------
    task automatic press_button(input entry_t b);
        buttons = b;
        repeat (2) @(negedge clock);
        buttons = 4'b0000;
        repeat (2) @(negedge clock);
    endtask

    task automatic pulse_start(input logic [1:0] lvl, input logic [1:0] mem,
                               input logic [1:0] tsel);
        level          = lvl;
        memory_select  = mem;
        timeout_select = tsel;
        start          = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic check_preview(input int n);
        int k;
        for (int i = 0; i < n; i++) begin
            for (k = 0; k < WAIT_LIT && leds == 4'b0000; k++) @(negedge clock);
            if (leds == 4'b0000) begin
                errors++;
                $display("preview entry %0d never lit at %0t", i, $time);
                return;
            end
            assert (leds == exp_seq[i] && $onehot(leds)) else begin
                errors++;
                $display("MISMATCH %0t: entry %0d shows %b, expected %b",
                         $time, i, leds, exp_seq[i]);
            end
            while (leds != 4'b0000) @(negedge clock);
        end
        // gap before play, no further entry may light
        repeat (LED_TICKS + 2) begin
            @(negedge clock);
            assert (leds == 4'b0000 && playing) else begin
                errors++;
                $display("MISMATCH %0t: extra preview entry or game stopped", $time);
            end
        end
    endtask

    task automatic wait_end(input bit want_won, input int limit);
        int k;
        for (k = 0; k < limit && !won && !lost; k++) @(negedge clock);
        assert (won == want_won && lost == !want_won) else begin
            errors++;
            $display("MISMATCH %0t: won %b lost %b, expected won %b",
                     $time, won, lost, want_won);
        end
    endtask

    function automatic entry_t wrong_button(input entry_t right, input int r);
        int c;
        c = 0;
        for (int b = 0; b < 4; b++) begin
            if (!right[b]) begin
                if (c == r) return entry_t'(1 << b);
                c++;
            end
        end
        return 4'b0000;
    endfunction

    function automatic int start_len(input logic [1:0] lvl, input logic [1:0] mem);
        int row;
        row = (lvl == 2'd3) ? 2 : lvl; // levels 2 and 3 share a row
        return START_LEN[row * 4 + mem];
    endfunction

    task automatic lose_by_wrong_press();
        exp_losses++;
        press_button(wrong_button(exp_seq[0], {$random(seed)} % 3));
        wait_end(1'b0, 20);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int len;
        reset          = 1'b1;
        start          = 1'b0;
        record         = 1'b0;
        ignore_timeout = 1'b0;
        buttons        = 4'b0000;
        level          = 2'd0;
        memory_select  = 2'd0;
        timeout_select = 2'd0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (leds == 0 && !buzzer && !playing && !won && !lost && wins == 0 && losses == 0)
            else begin
                errors++;
                $display("MISMATCH %0t: outputs not cleared after reset", $time);
            end

        // record 16 patterns, only possible from idle
        memory_select = MEM_CUSTOM;
        record        = 1'b1;
        @(negedge clock);
        for (int i = 0; i < 16; i++) begin
            custom_seq[i] = entry_t'(1 << ({$random(seed)} % 4));
            press_button(custom_seq[i]);
        end
        record = 1'b0;
        @(negedge clock);
        for (int i = 0; i < 16; i++) exp_seq[i] = custom_seq[i];
        pulse_start(2'd0, MEM_CUSTOM, 2'd0);
        check_preview(start_len(2'd0, MEM_CUSTOM));
        lose_by_wrong_press();

        // full game on fixed memory 1, level 0
        for (int i = 0; i < 16; i++) exp_seq[i] = FIXED_SEQ[1][i];
        pulse_start(2'd0, 2'd1, 2'd0);
        len = start_len(2'd0, 2'd1);
        forever begin
            check_preview(len);
            if (len == FULL_LEN) exp_wins++;
            for (int i = 0; i < len; i++) press_button(exp_seq[i]);
            if (len == FULL_LEN) break;
            len++;
        end
        wait_end(1'b1, 20);

        // random wrong press on memory 0
        for (int i = 0; i < 16; i++) exp_seq[i] = FIXED_SEQ[0][i];
        pulse_start(2'd2, 2'd0, 2'd0);
        check_preview(start_len(2'd2, 2'd0));
        lose_by_wrong_press();

        // shortest timeout with no press, half a unit after entering play
        for (int i = 0; i < 16; i++) exp_seq[i] = FIXED_SEQ[2][i];
        pulse_start(2'd2, 2'd2, 2'd3);
        check_preview(start_len(2'd2, 2'd2));
        exp_losses++;
        wait_end(1'b0, TIMEOUT_UNIT / 2 + 4);

        // same wait with the timeout masked
        ignore_timeout = 1'b1;
        pulse_start(2'd2, 2'd2, 2'd3);
        check_preview(start_len(2'd2, 2'd2));
        repeat (4 * TIMEOUT_UNIT) begin
            @(negedge clock);
            assert (!lost) else begin
                errors++;
                $display("MISMATCH %0t: timeout fired while ignored", $time);
            end
        end
        lose_by_wrong_press();

        $display("errors: %0d in testbench, %0d in rule checks",
                 errors, i_playseq_top.i_asserts.fail_count);
        if (errors == 0 && i_playseq_top.i_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * 100);
        $display("run did not finish within %0d cycles", WATCH_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== sources.f ====
source/playseq_pkg.sv
source/playseq_ctrl_if.sv
source/playseq_sequence_store.sv
source/playseq_timers.sv
source/playseq_datapath.sv
source/playseq_control.sv
source/playseq_top.sv
test/playseq_asserts.sv
test/playseq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory game testbench with Verilator and run it.
# Exit status is nonzero unless the log holds the pass message.
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module playseq_tb -o playseq_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/playseq_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
